/* nes_io_pkg.sv */
/*
 * shared widths, vector typedefs and packed structs for the emulator front end
 * memory port, loader, softcore and toggle port bundles, bridge FSM states
 */
`default_nettype none

package nes_io_pkg;

    //////////////////// widths
    localparam int MEM_ADDR_W   = 22;   // emulator byte address
    localparam int RV_ADDR_W    = 23;   // softcore byte address
    localparam int RV_WADDR_W   = 20;   // half-word address on toggle port
    localparam int BUTTONS_W    = 12;   // SNES layout

    typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
    typedef logic [7:0]             byte_t;
    typedef logic [15:0]            half_t;
    typedef logic [31:0]            word_t;
    typedef logic [RV_ADDR_W-1:0]   rv_addr_t;
    typedef logic [RV_WADDR_W-1:0]  rv_word_addr_t;  // addr[20:2] plus word select
    typedef logic [3:0]             strobe_t;
    typedef logic [1:0]             ds_t;
    typedef logic [BUTTONS_W-1:0]   buttons_t;       // low 8 bits are console buttons
    typedef logic [7:0]             pad_bits_t;

    // pad bit positions
    localparam int BUTTON_SELECT = 2;
    localparam int BUTTON_DOWN   = 5;

    //////////////////// bundles
    typedef struct packed {
        mem_addr_t addr;
        byte_t     wdata;
        logic      write;
        logic      read;
    } mem_port_s;

    typedef struct packed {
        mem_addr_t addr;
        byte_t     data;
        logic      write;
    } loader_wr_s;

    typedef struct packed {
        logic     valid;    // edge starts a request
        rv_addr_t addr;
        word_t    wdata;
        strobe_t  wstrb;    // all zero means read
    } rv_req_s;

    typedef struct packed {
        rv_word_addr_t addr;
        half_t         wdata;
        ds_t           ds;
        logic          we;
        logic          req;  // toggles once per transaction
    } rv_mem_req_s;

    typedef enum logic [2:0] {
        RV_IDLE_REQ0,   // idle, issue first half
        RV_WAIT0_REQ1,  // wait first ack, issue second half
        RV_DATA0,       // capture low read half
        RV_WAIT1,       // wait second ack
        RV_DATA1        // high half live, ready out
    } rv_state_e;

endpackage

`default_nettype wire

/* reset_sequencer.sv */
/*
 * power-on hold counter and home-combination core reset
 * emulator reset from loading edges, half-rate clock reference
 */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
    parameter int RESET_HOLD = 255      // cycles of hold after sys_resetn
) (
    input  logic                 clk,
    input  logic                 sys_resetn,
    input  nes_io_pkg::buttons_t pad1_buttons,
    input  logic                 loading,
    output logic                 core_resetn,
    output logic                 emu_reset,
    output logic                 clkref
);

    // counter wide enough for the hold value, at least one bit
    localparam int CNT_W = (RESET_HOLD > 1) ? $clog2(RESET_HOLD + 1) : 1;

    logic [CNT_W-1:0] hold_cnt;
    logic             home_combo;
    logic             loading_r;
    logic             load_rise;
    logic             load_fall;

    ////////////////////
    // core reset
    ////////////////////

    // select + down acts as a home button
    assign home_combo = pad1_buttons[nes_io_pkg::BUTTON_SELECT] &
                        pad1_buttons[nes_io_pkg::BUTTON_DOWN];

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            hold_cnt    <= CNT_W'(RESET_HOLD);
            core_resetn <= 1'b0;
        end else if (hold_cnt != '0) begin
            hold_cnt    <= hold_cnt - 1'b1;   // still in power-on hold
            core_resetn <= 1'b0;
        end else begin
            core_resetn <= ~home_combo;       // one register of delay
        end
    end

    ////////////////////
    // emulator reset, clkref
    ////////////////////

    assign load_rise = loading & ~loading_r;
    assign load_fall = ~loading & loading_r;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_r <= 1'b0;
            emu_reset <= 1'b1;
            clkref    <= 1'b0;
        end else begin
            loading_r <= loading;
            clkref    <= ~clkref;             // half rate
            if (load_fall) begin
                emu_reset <= 1'b0;            // rom in place, run
                clkref    <= 1'b1;            // realign phase
            end else if (load_rise) begin
                emu_reset <= 1'b1;
            end
            // core held in reset overrides everything
            if (!core_resetn)
                emu_reset <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* loader_port_mux.sv */
/*
 * loader write stretch to two cycles with address/data latch
 * CPU memory port selection while a ROM is loading
 */
`timescale 1ns/1ps
`default_nettype none

module loader_port_mux (
    input  logic                   clk,
    input  logic                   core_resetn,
    input  logic                   loading,
    input  nes_io_pkg::loader_wr_s loader,
    input  nes_io_pkg::mem_port_s  cpu_port,
    output nes_io_pkg::mem_port_s  mem_port
);

    logic                  loader_write_r;    // previous loader strobe
    logic                  write_stretch;     // two cycles per loader write
    nes_io_pkg::mem_addr_t addr_latch;
    nes_io_pkg::byte_t     data_latch;

    ////////////////////
    // stretch and latch
    ////////////////////

    always_ff @(posedge clk) begin
        if (!core_resetn) begin
            loader_write_r <= 1'b0;
            write_stretch  <= 1'b0;
        end else begin
            loader_write_r <= loader.write;
            write_stretch  <= loader.write | loader_write_r;  // t+1 and t+2
        end
    end

    // payload only, held until next loader write
    always_ff @(posedge clk) begin
        if (loader.write) begin
            addr_latch <= loader.addr;
            data_latch <= loader.data;
        end
    end

    ////////////////////
    // port select
    ////////////////////

    always_comb begin
        if (loading) begin
            mem_port.addr  = addr_latch;
            mem_port.wdata = data_latch;
            mem_port.read  = 1'b0;            // no CPU reads during load
        end else begin
            mem_port.addr  = cpu_port.addr;   // straight through
            mem_port.wdata = cpu_port.wdata;
            mem_port.read  = cpu_port.read;
        end
        // either source may write
        mem_port.write = write_stretch | cpu_port.write;
    end

endmodule

`default_nettype wire

/* rv_mem_bridge.sv */
/*
 * softcore 32-bit valid/ready request to 16-bit toggle port bridge
 * one or two half transactions, partial writes skip untouched half
 */
`timescale 1ns/1ps
`default_nettype none

module rv_mem_bridge (
    input  logic                    clk,
    input  logic                    core_resetn,
    input  nes_io_pkg::rv_req_s     rv_req,
    output logic                    rv_ready,
    output nes_io_pkg::word_t       rv_rdata,
    output nes_io_pkg::rv_mem_req_s rv_mem,
    input  logic                    rv_mem_ack,
    input  nes_io_pkg::half_t       rv_mem_dout
);

    nes_io_pkg::rv_state_e state;
    nes_io_pkg::ds_t       ds;
    nes_io_pkg::half_t     dout0;         // low read half
    logic                  valid_r;
    logic                  new_req;       // edge seen while busy
    logic                  new_req_t;     // edge this cycle
    logic                  word;          // 0 low half, 1 high half
    logic                  req;
    logic                  is_write;
    logic                  acked;

    assign is_write  = rv_req.wstrb != '0;
    assign new_req_t = rv_req.valid & ~valid_r;
    assign acked     = req == rv_mem_ack;   // toggle pair matched

    ////////////////////
    // toggle port outputs
    ////////////////////

    assign rv_mem.addr  = {rv_req.addr[20:2], word};
    assign rv_mem.wdata = word ? rv_req.wdata[31:16] : rv_req.wdata[15:0];
    assign rv_mem.ds    = ds;
    assign rv_mem.we    = is_write;
    assign rv_mem.req   = req;

    // high half straight from the port, low half registered
    assign rv_rdata = {rv_mem_dout, dout0};

    ////////////////////
    // FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (!core_resetn) begin
            state    <= nes_io_pkg::RV_IDLE_REQ0;
            rv_ready <= 1'b0;
            req      <= 1'b0;
            valid_r  <= 1'b0;
            new_req  <= 1'b0;
            word     <= 1'b0;
            ds       <= '0;
        end else begin
            valid_r  <= rv_req.valid;
            rv_ready <= 1'b0;                       // single cycle pulse
            if (new_req_t)
                new_req <= 1'b1;                    // remember for later

            case (state)
                nes_io_pkg::RV_IDLE_REQ0: begin
                    if (new_req || new_req_t) begin
                        new_req <= 1'b0;
                        req     <= ~req;            // first transaction
                        if (is_write && rv_req.wstrb[1:0] == 2'b00) begin
                            word  <= 1'b1;          // upper half only
                            ds    <= rv_req.wstrb[3:2];
                            state <= nes_io_pkg::RV_WAIT1;
                        end else begin
                            word  <= 1'b0;
                            ds    <= is_write ? rv_req.wstrb[1:0] : 2'b11;
                            state <= nes_io_pkg::RV_WAIT0_REQ1;
                        end
                    end
                end

                nes_io_pkg::RV_WAIT0_REQ1: begin
                    if (acked) begin
                        word <= 1'b1;
                        if (is_write) begin
                            ds <= rv_req.wstrb[3:2];
                            if (rv_req.wstrb[3:2] == 2'b00) begin
                                rv_ready <= 1'b1;   // lower half only, done
                                state    <= nes_io_pkg::RV_IDLE_REQ0;
                            end else begin
                                req   <= ~req;      // second write half
                                state <= nes_io_pkg::RV_WAIT1;
                            end
                        end else begin
                            req   <= ~req;          // high read half
                            ds    <= 2'b11;
                            state <= nes_io_pkg::RV_DATA0;
                        end
                    end
                end

                nes_io_pkg::RV_DATA0: begin
                    dout0 <= rv_mem_dout;           // low half one cycle after ack
                    state <= nes_io_pkg::RV_WAIT1;
                end

                nes_io_pkg::RV_WAIT1: begin
                    if (acked) begin
                        if (is_write) begin
                            rv_ready <= 1'b1;
                            state    <= nes_io_pkg::RV_IDLE_REQ0;
                        end else begin
                            state <= nes_io_pkg::RV_DATA1;
                        end
                    end
                end

                nes_io_pkg::RV_DATA1: begin
                    rv_ready <= 1'b1;               // high half live on rdata
                    state    <= nes_io_pkg::RV_IDLE_REQ0;
                end

                default: state <= nes_io_pkg::RV_IDLE_REQ0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* joypad_serializer.sv */
/*
 * two strobe-loaded joypad shift registers
 * shift on falling pad clock, ones fill from the top
 */
`timescale 1ns/1ps
`default_nettype none

module joypad_serializer (
    input  logic                 clk,
    input  logic                 core_resetn,
    input  nes_io_pkg::buttons_t pad1_buttons,
    input  nes_io_pkg::buttons_t pad2_buttons,
    input  logic                 joypad_strobe,
    input  logic [1:0]           joypad_clock,
    output logic [1:0]           joypad_data
);

    nes_io_pkg::buttons_t  pads [2];
    nes_io_pkg::pad_bits_t bits [2];
    logic [1:0]            last_clock;        // pad clocks one cycle late

    assign pads[0] = pad1_buttons;
    assign pads[1] = pad2_buttons;

    always_ff @(posedge clk) begin
        if (!core_resetn) begin
            bits[0]    <= '1;
            bits[1]    <= '1;
            last_clock <= '0;
        end else begin
            last_clock <= joypad_clock;
            for (int i = 0; i < 2; i++) begin
                if (joypad_strobe)
                    bits[i] <= pads[i][7:0];              // console buttons only
                if (!joypad_clock[i] && last_clock[i])
                    bits[i] <= {1'b1, bits[i][7:1]};      // falling edge shift
            end
        end
    end

    // lsb first to the core
    assign joypad_data[0] = bits[0][0];
    assign joypad_data[1] = bits[1][0];

endmodule

`default_nettype wire

/* nes_io_top.sv */
/*
 * memory and I/O front end top level
 * reset sequencing, loader port mux, softcore bridge, joypads
 */
`timescale 1ns/1ps
`default_nettype none

module nes_io_top #(
    parameter int RESET_HOLD = 255
) (
    input  logic                    clk,
    input  logic                    sys_resetn,
    input  nes_io_pkg::buttons_t    pad1_buttons,
    input  nes_io_pkg::buttons_t    pad2_buttons,
    input  logic                    loading,
    input  nes_io_pkg::loader_wr_s  loader,
    input  nes_io_pkg::mem_port_s   cpu_port,
    input  nes_io_pkg::rv_req_s     rv_req,
    input  logic                    rv_mem_ack,
    input  nes_io_pkg::half_t       rv_mem_dout,
    input  logic                    joypad_strobe,
    input  logic [1:0]              joypad_clock,
    output logic                    core_resetn,
    output logic                    emu_reset,
    output logic                    clkref,
    output nes_io_pkg::mem_port_s   mem_port,
    output logic                    rv_ready,
    output nes_io_pkg::word_t       rv_rdata,
    output nes_io_pkg::rv_mem_req_s rv_mem,
    output logic [1:0]              joypad_data
);

    // core_resetn fans out to the other blocks
    reset_sequencer #(
        .RESET_HOLD (RESET_HOLD)
    ) reset_sequencer_i (
        .clk          (clk),
        .sys_resetn   (sys_resetn),
        .pad1_buttons (pad1_buttons),
        .loading      (loading),
        .core_resetn  (core_resetn),
        .emu_reset    (emu_reset),
        .clkref       (clkref)
    );

    loader_port_mux loader_port_mux_i (
        .clk         (clk),
        .core_resetn (core_resetn),
        .loading     (loading),
        .loader      (loader),
        .cpu_port    (cpu_port),
        .mem_port    (mem_port)
    );

    rv_mem_bridge rv_mem_bridge_i (
        .clk         (clk),
        .core_resetn (core_resetn),
        .rv_req      (rv_req),
        .rv_ready    (rv_ready),
        .rv_rdata    (rv_rdata),
        .rv_mem      (rv_mem),
        .rv_mem_ack  (rv_mem_ack),
        .rv_mem_dout (rv_mem_dout)
    );

    joypad_serializer joypad_serializer_i (
        .clk           (clk),
        .core_resetn   (core_resetn),
        .pad1_buttons  (pad1_buttons),
        .pad2_buttons  (pad2_buttons),
        .joypad_strobe (joypad_strobe),
        .joypad_clock  (joypad_clock),
        .joypad_data   (joypad_data)
    );

endmodule

`default_nettype wire

/* tb_mem_responder.sv */
/*
 * toggle-port memory model for the softcore bridge
 * 16-bit array, byte selects on writes, LFSR response delay of 1 to 4 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_responder (
    input  logic                    clk,
    input  logic                    sys_resetn,
    input  nes_io_pkg::rv_mem_req_s rv_mem,
    output logic                    rv_mem_ack,
    output nes_io_pkg::half_t       rv_mem_dout,
    output int unsigned             toggle_count    // transactions seen
);

    nes_io_pkg::half_t       mem [0:(1 << nes_io_pkg::RV_WADDR_W) - 1];
    nes_io_pkg::rv_mem_req_s cur;               // transaction in flight
    logic [31:0]             lfsr;
    logic [31:0]             lfsr_1;
    logic [31:0]             lfsr_2;
    logic [2:0]              wait_cnt;
    logic                    busy;

    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per delay bit
    assign lfsr_1 = lfsr_next(lfsr);
    assign lfsr_2 = lfsr_next(lfsr_1);

    initial begin
        rv_mem_ack  = 1'b0;
        rv_mem_dout = '0;
    end

    always @(posedge clk) begin
        if (!sys_resetn) begin
            lfsr         <= 32'd77794;
            rv_mem_ack   <= 1'b0;
            rv_mem_dout  <= '0;
            toggle_count <= 0;
            wait_cnt     <= '0;
            busy         <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 3'd1) begin
                busy       <= 1'b0;
                rv_mem_ack <= cur.req;          // answer the toggle
                if (cur.we) begin
                    if (cur.ds[0])
                        mem[cur.addr][7:0] <= cur.wdata[7:0];
                    if (cur.ds[1])
                        mem[cur.addr][15:8] <= cur.wdata[15:8];
                end else begin
                    rv_mem_dout <= mem[cur.addr];   // held until next answer
                end
            end else begin
                wait_cnt <= wait_cnt - 3'd1;
            end
        end else if (rv_mem.req != rv_mem_ack) begin
            cur          <= rv_mem;             // new toggle seen
            busy         <= 1'b1;
            wait_cnt     <= 3'd1 + {1'b0, lfsr_2[0], lfsr_1[0]};
            lfsr         <= lfsr_2;
            toggle_count <= toggle_count + 1;
        end
    end

endmodule

`default_nettype wire

/* tb_nes_io_sva.sv */
/*
 * concurrent checks on the bridge toggle port and the loader write path
 * bound into the top level, which holds both blocks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_nes_io_sva (
    input logic                    clk,
    input logic                    core_resetn,
    input logic                    loading,
    input nes_io_pkg::loader_wr_s  loader,
    input nes_io_pkg::mem_port_s   cpu_port,
    input nes_io_pkg::mem_port_s   mem_port,
    input nes_io_pkg::rv_mem_req_s rv_mem,
    input logic                    rv_mem_ack,
    input logic                    rv_ready
);

    // new toggle only once the last one was answered
    req_no_overlap: assert property (@(posedge clk) disable iff (!core_resetn)
        (rv_mem.req != $past(rv_mem.req)) |-> $past(rv_mem.req == rv_mem_ack))
        else $error("request toggled while a transaction was outstanding");

    // ready only once the last toggle is answered, one cycle wide
    ready_pulse: assert property (@(posedge clk) disable iff (!core_resetn)
        rv_ready |-> (rv_mem.req == rv_mem_ack) ##1 !rv_ready)
        else $error("ready not a single pulse after the final acknowledge");

    // loader strobe stretched to exactly two port cycles
    loader_two_cycles: assert property (@(posedge clk) disable iff (!core_resetn)
        (loading && loader.write && !cpu_port.write) |=>
            mem_port.write ##1 mem_port.write ##1 !mem_port.write)
        else $error("loader write not stretched to two port cycles");

endmodule

bind nes_io_top tb_nes_io_sva tb_nes_io_sva_i (
    .clk         (clk),
    .core_resetn (core_resetn),
    .loading     (loading),
    .loader      (loader),
    .cpu_port    (cpu_port),
    .mem_port    (mem_port),
    .rv_mem      (rv_mem),
    .rv_mem_ack  (rv_mem_ack),
    .rv_ready    (rv_ready)
);

`default_nettype wire

/* tb_nes_io.sv */
/*
 * testbench for the emulator memory and I/O front end
 * reset sequencing, loader path, softcore table, joypads
 */
`timescale 1ns/1ps
`default_nettype none

module tb_nes_io;

    localparam int RESET_HOLD = 16;
    localparam int TIMEOUT    = 200;   // cycles per wait
    localparam int NUM_OPS    = 10;

    typedef enum logic {OP_WRITE, OP_READ} op_e;

    typedef struct packed {
        op_e                  op;
        nes_io_pkg::rv_addr_t addr;
        nes_io_pkg::word_t    data;
        nes_io_pkg::strobe_t  strb;
        nes_io_pkg::word_t    expected;   // read data
        logic [1:0]           halves;     // toggle transactions
    } rv_op_s;

    logic                    clk;
    logic                    sys_resetn;
    nes_io_pkg::buttons_t    pad1_buttons;
    nes_io_pkg::buttons_t    pad2_buttons;
    logic                    loading;
    nes_io_pkg::loader_wr_s  loader;
    nes_io_pkg::mem_port_s   cpu_port;
    nes_io_pkg::rv_req_s     rv_req;
    logic                    rv_mem_ack;
    nes_io_pkg::half_t       rv_mem_dout;
    logic                    joypad_strobe;
    logic [1:0]              joypad_clock;
    logic                    core_resetn;
    logic                    emu_reset;
    logic                    clkref;
    nes_io_pkg::mem_port_s   mem_port;
    logic                    rv_ready;
    nes_io_pkg::word_t       rv_rdata;
    nes_io_pkg::rv_mem_req_s rv_mem;
    logic [1:0]              joypad_data;
    int unsigned             toggle_count;

    //////////////////// stimulus table
    // op, byte address, write data, strobes, expected read word, halves
    rv_op_s rv_ops [NUM_OPS] = '{
        '{OP_WRITE, 23'h000100, 32'h11223344, 4'hF, 32'h0,        2'd2},
        '{OP_WRITE, 23'h000204, 32'hCAFEF00D, 4'hF, 32'h0,        2'd2},
        '{OP_READ,  23'h000100, 32'h0,        4'h0, 32'h11223344, 2'd2},
        '{OP_READ,  23'h000204, 32'h0,        4'h0, 32'hCAFEF00D, 2'd2},
        '{OP_WRITE, 23'h000100, 32'hAABBCCDD, 4'h3, 32'h0,        2'd1},  // low half only
        '{OP_READ,  23'h000100, 32'h0,        4'h0, 32'h1122CCDD, 2'd2},
        '{OP_WRITE, 23'h000204, 32'h55667788, 4'hC, 32'h0,        2'd1},  // high half only
        '{OP_READ,  23'h000204, 32'h0,        4'h0, 32'h5566F00D, 2'd2},
        '{OP_WRITE, 23'h000100, 32'h0000EE00, 4'h2, 32'h0,        2'd1},  // single byte
        '{OP_READ,  23'h000100, 32'h0,        4'h0, 32'h1122EEDD, 2'd2}
    };

    nes_io_top #(
        .RESET_HOLD (RESET_HOLD)
    ) nes_io_top_i (
        .clk           (clk),
        .sys_resetn    (sys_resetn),
        .pad1_buttons  (pad1_buttons),
        .pad2_buttons  (pad2_buttons),
        .loading       (loading),
        .loader        (loader),
        .cpu_port      (cpu_port),
        .rv_req        (rv_req),
        .rv_mem_ack    (rv_mem_ack),
        .rv_mem_dout   (rv_mem_dout),
        .joypad_strobe (joypad_strobe),
        .joypad_clock  (joypad_clock),
        .core_resetn   (core_resetn),
        .emu_reset     (emu_reset),
        .clkref        (clkref),
        .mem_port      (mem_port),
        .rv_ready      (rv_ready),
        .rv_rdata      (rv_rdata),
        .rv_mem        (rv_mem),
        .joypad_data   (joypad_data)
    );

    tb_mem_responder mem_responder_i (
        .clk          (clk),
        .sys_resetn   (sys_resetn),
        .rv_mem       (rv_mem),
        .rv_mem_ack   (rv_mem_ack),
        .rv_mem_dout  (rv_mem_dout),
        .toggle_count (toggle_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns
    end

    //////////////////// helpers
    // inputs change 1 ns after the edge, outputs sampled there too
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("ERRORS FOUND");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic check_reset_hold();
        int low_cycles;
        int n;
        low_cycles = 0;
        for (n = 0; n < TIMEOUT && core_resetn !== 1'b1; n++) begin
            step();
            if (core_resetn !== 1'b1)
                low_cycles++;
        end
        if (core_resetn !== 1'b1)
            stop_on_timeout("core reset release");
        check_value("power-on hold cycles", RESET_HOLD, low_cycles);
        check_value("emu_reset after reset", 1, emu_reset);
        // select + down is the home combination
        pad1_buttons[nes_io_pkg::BUTTON_SELECT] = 1'b1;
        pad1_buttons[nes_io_pkg::BUTTON_DOWN]   = 1'b1;
        step();
        check_value("home combo resets core", 0, core_resetn);
        pad1_buttons = '0;
        step();
        check_value("home combo released", 1, core_resetn);
    endtask

    task automatic write_loader(input nes_io_pkg::mem_addr_t load_addr,
                                input nes_io_pkg::byte_t load_data);
        nes_io_pkg::mem_port_s expected;
        expected = '{addr: load_addr, wdata: load_data, write: 1'b1, read: 1'b0};
        loader   = '{addr: load_addr, data: load_data, write: 1'b1};
        step();
        loader.write = 1'b0;
        check_value("loader write cycle 1", expected, mem_port);
        step();
        check_value("loader write cycle 2", expected, mem_port);
        step();
        expected.write = 1'b0;
        check_value("loader write done", expected, mem_port);
    endtask

    task automatic check_loading();
        nes_io_pkg::mem_port_s cpu_value;
        loading  = 1'b1;
        cpu_port = '{addr: 22'h000003, wdata: 8'h99, write: 1'b0, read: 1'b1};
        step();
        check_value("emu_reset while loading", 1, emu_reset);
        write_loader(22'h000010, 8'h4E);
        write_loader(22'h3FFFFF, 8'hA1);
        loading = 1'b0;
        step();
        check_value("emu_reset after load", 0, emu_reset);
        check_value("clkref realigned", 1, clkref);
        step();
        check_value("clkref toggles", 0, clkref);
        loading = 1'b1;   // second load, rising edge visible now
        check_value("emu_reset before rise", 0, emu_reset);
        step();
        check_value("emu_reset on rise", 1, emu_reset);
        loading = 1'b0;
        step();
        check_value("emu_reset on fall", 0, emu_reset);
        check_value("clkref on fall", 1, clkref);
        // cpu straight through with loading low
        cpu_value = '{addr: 22'h1ABCDE, wdata: 8'h5C, write: 1'b0, read: 1'b1};
        cpu_port  = cpu_value;
        #1;
        check_value("cpu read passthrough", cpu_value, mem_port);
        cpu_value = '{addr: 22'h00F00F, wdata: 8'hA7, write: 1'b1, read: 1'b0};
        cpu_port  = cpu_value;
        #1;
        check_value("cpu write passthrough", cpu_value, mem_port);
        cpu_port = '0;
    endtask

    task automatic wait_rv_ready(input string what);
        int n;
        n = 0;
        do begin
            step();
            n++;
        end while (rv_ready !== 1'b1 && n < TIMEOUT);
        if (rv_ready !== 1'b1)
            stop_on_timeout(what);
    endtask

    task automatic run_rv_table();
        rv_op_s      op;
        int unsigned start_count;
        for (int i = 0; i < NUM_OPS; i++) begin
            op           = rv_ops[i];
            start_count  = toggle_count;
            rv_req.addr  = op.addr;
            rv_req.wdata = op.data;
            rv_req.wstrb = op.strb;
            rv_req.valid = 1'b1;        // rising edge starts it
            wait_rv_ready($sformatf("ready of rv op %0d", i));
            if (op.op == OP_READ)
                check_value($sformatf("rv op %0d read data", i), op.expected, rv_rdata);
            check_value($sformatf("rv op %0d halves", i), op.halves,
                        toggle_count - start_count);
            rv_req.valid = 1'b0;
            step();
        end
    endtask

    task automatic pulse_pad_clock(input int pad);
        joypad_clock[pad] = 1'b1;
        step();
        joypad_clock[pad] = 1'b0;
        step();
    endtask

    task automatic check_joypads();
        nes_io_pkg::buttons_t pads [2];
        logic                 expected;
        logic                 other;
        pads[0]       = 12'h05A;   // no select + down
        pads[1]       = 12'hF3C;   // upper bits never shifted
        pad1_buttons  = pads[0];
        pad2_buttons  = pads[1];
        joypad_strobe = 1'b1;
        step();
        joypad_strobe = 1'b0;
        step();
        for (int p = 0; p < 2; p++) begin
            other = (p == 0) ? pads[1][0] : 1'b1;   // idle pad holds its bit
            for (int k = 0; k < 10; k++) begin
                expected = (k < 8) ? pads[p][k] : 1'b1;
                check_value($sformatf("pad %0d bit %0d", p + 1, k), expected, joypad_data[p]);
                check_value($sformatf("pad %0d idle", 2 - p), other, joypad_data[1 - p]);
                pulse_pad_clock(p);
            end
        end
    endtask

    //////////////////// main sequence
    initial begin
        sys_resetn    = 1'b0;
        pad1_buttons  = '0;
        pad2_buttons  = '0;
        loading       = 1'b0;
        loader        = '0;
        cpu_port      = '0;
        rv_req        = '0;
        joypad_strobe = 1'b0;
        joypad_clock  = '0;
        repeat (8) step();
        sys_resetn = 1'b1;
        check_reset_hold();
        check_loading();
        run_rv_table();
        check_joypads();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
nes_io_pkg.sv
reset_sequencer.sv
loader_port_mux.sv
rv_mem_bridge.sv
joypad_serializer.sv
nes_io_top.sv
tb_mem_responder.sv
tb_nes_io_sva.sv
tb_nes_io.sv

/* Makefile */
# Verilator simulation of the emulator memory and I/O front end

VERILATOR ?= verilator
TOP       ?= tb_nes_io
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= ERRORS FOUND
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
